//--- verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // Issue buffer geometry.
  localparam int buffer_depth = 8;
  localparam int count_width = $clog2(buffer_depth + 1);
  localparam int ptr_width = $clog2(buffer_depth);

  // RV32 major opcodes seen by the predecoder.
  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  // System also covers fence, CSR access and illegal words.
  typedef enum logic [2:0] {
    cls_alu,
    cls_branch,
    cls_jump,
    cls_upper,
    cls_load,
    cls_store,
    cls_muldiv,
    cls_system
  } op_class_e;

  typedef struct packed {
    logic [31:0] word;
    op_class_e   cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        wren;
    logic        rden1;
    logic        rden2;
  } issue_op_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] word;
  } fetch_slot_t;

  typedef struct packed {
    logic      valid;
    issue_op_t op;
  } issue_slot_t;

  // Classes that may ride in the younger lane.
  function automatic logic is_basic(op_class_e cls);
    logic basic;
    case (cls)
      cls_alu,
      cls_branch,
      cls_jump,
      cls_upper: basic = 1'b1;
      default:   basic = 1'b0;
    endcase
    return basic;
  endfunction

endpackage

`default_nettype wire

//--- verilog/instr_predecode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_predecode (
  input  issue_pkg::fetch_slot_t slot,
  output issue_pkg::issue_slot_t op
);
  import issue_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_ok;
  op_class_e  cls;
  logic       has_rd;
  logic       has_rs1;
  logic       has_rs2;

  assign opcode = slot.word[6:0];
  assign funct3 = slot.word[14:12];
  assign funct7 = slot.word[31:25];

  // Shift immediates only allow the srai variant of funct7.
  assign shift_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                    (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                    1'b1;

  always_comb begin
    cls = cls_system;
    has_rd = 1'b0;
    has_rs1 = 1'b0;
    has_rs2 = 1'b0;
    case (opcode)
      opc_op: begin
        if (funct7 == 7'b0000001) begin
          cls = cls_muldiv;
          {has_rd, has_rs1, has_rs2} = 3'b111;
        end else if (funct7 == 7'b0000000 ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          cls = cls_alu;
          {has_rd, has_rs1, has_rs2} = 3'b111;
        end
      end
      opc_op_imm: begin
        if (shift_ok) begin
          cls = cls_alu;
          {has_rd, has_rs1} = 2'b11;
        end
      end
      opc_lui, opc_auipc: begin
        cls = cls_upper;
        has_rd = 1'b1;
      end
      opc_jal: begin
        cls = cls_jump;
        has_rd = 1'b1;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          cls = cls_jump;
          {has_rd, has_rs1} = 2'b11;
        end
      end
      opc_branch: begin
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          cls = cls_branch;
          {has_rs1, has_rs2} = 2'b11;
        end
      end
      opc_load: begin
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
          cls = cls_load;
          {has_rd, has_rs1} = 2'b11;
        end
      end
      opc_store: begin
        if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
          cls = cls_store;
          {has_rs1, has_rs2} = 2'b11;
        end
      end
      opc_system: begin
        // CSR access; funct3 0 is ecall, ebreak, mret or wfi.
        if (funct3 != 3'b000 && funct3 != 3'b100) begin
          has_rd = 1'b1;
          has_rs1 = ~funct3[2];
        end
      end
      default: begin
        // Fence and illegal words keep the system class.
        cls = cls_system;
      end
    endcase
  end

  assign op.valid = slot.valid;
  assign op.op.word = slot.word;
  assign op.op.cls = cls;
  assign op.op.rd = slot.word[11:7];
  assign op.op.rs1 = slot.word[19:15];
  assign op.op.rs2 = slot.word[24:20];
  assign op.op.wren = has_rd && (slot.word[11:7] != 5'd0);
  assign op.op.rden1 = has_rs1 && (slot.word[19:15] != 5'd0);
  assign op.op.rden2 = has_rs2 && (slot.word[24:20] != 5'd0);

  // Only a known major opcode may leave the system class.
  a_class_legal: assert property (@(slot)
    (slot.valid && op.op.cls != cls_system) |->
      opcode inside {opc_load, opc_op_imm, opc_auipc, opc_store, opc_op,
                     opc_lui, opc_branch, opc_jalr, opc_jal});

endmodule

`default_nettype wire

//--- verilog/issue_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module issue_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  issue_pkg::issue_slot_t in0,
  input  issue_pkg::issue_slot_t in1,
  output logic                  in_ready,
  output issue_pkg::issue_slot_t lane0,
  output issue_pkg::issue_slot_t lane1,
  input  logic                  issue_ready
);
  import issue_pkg::*;

  issue_op_t              mem [buffer_depth];
  logic [ptr_width-1:0]   rd_ptr;
  logic [ptr_width-1:0]   wr_ptr;
  logic [count_width-1:0] count;

  logic                   acc0;
  logic                   acc1;
  logic [1:0]             num_in;
  logic [count_width-1:0] avail;
  issue_op_t              rec0;
  issue_op_t              rec1;
  logic                   raw;
  logic                   pair_ok;
  logic                   valid0;
  logic                   valid1;
  logic [1:0]             consumed;
  logic [count_width-1:0] count_next;
  logic                   in_ready_next;

  // Slot1 only comes with slot0, so acceptance is in order.
  assign acc0 = in0.valid && in_ready && !flush;
  assign acc1 = in1.valid && in_ready && !flush;
  assign num_in = {1'b0, acc0} + {1'b0, acc1};

  // Incoming records count as available in the same cycle.
  assign avail = count + count_width'(num_in);

  // Oldest two records, from storage or straight from the inputs.
  always_comb begin
    if (count != '0) begin
      rec0 = mem[rd_ptr];
    end else begin
      rec0 = in0.op;
    end
    if (count >= count_width'(2)) begin
      rec1 = mem[rd_ptr + ptr_width'(1)];
    end else if (count == count_width'(1)) begin
      rec1 = in0.op;
    end else begin
      rec1 = in1.op;
    end
  end

  // Younger lane must not read what the older lane writes.
  assign raw = rec0.wren &&
               ((rec1.rden1 && rec1.rs1 == rec0.rd) ||
                (rec1.rden2 && rec1.rs2 == rec0.rd));
  assign pair_ok = is_basic(rec1.cls) && !raw;

  assign valid0 = !flush && (avail >= count_width'(1));
  assign valid1 = !flush && (avail >= count_width'(2)) && pair_ok;

  assign lane0.valid = valid0;
  assign lane0.op = rec0;
  assign lane1.valid = valid1;
  assign lane1.op = rec1;

  assign consumed = issue_ready ? ({1'b0, valid0} + {1'b0, valid1}) : 2'd0;
  assign count_next = avail - count_width'(consumed);

  // Leave room for a full pair on the next accept.
  assign in_ready_next = count_next <= count_width'(buffer_depth - 2);

  always_ff @(posedge clock) begin
    if (acc0) begin
      mem[wr_ptr] <= in0.op;
    end
    if (acc1) begin
      mem[wr_ptr + ptr_width'(1)] <= in1.op;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      in_ready <= 1'b1;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      in_ready <= 1'b1;
    end else begin
      rd_ptr <= rd_ptr + ptr_width'(consumed);
      wr_ptr <= wr_ptr + ptr_width'(num_in);
      count <= count_next;
      in_ready <= in_ready_next;
    end
  end

  // An accepted pair always finds free entries.
  a_no_accept_stalled: assert property (@(posedge clock) disable iff (!reset)
    (acc0 || acc1) |-> count <= count_width'(buffer_depth - 2));

  a_count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= count_width'(buffer_depth));

  a_lane_order: assert property (@(posedge clock) disable iff (!reset)
    lane1.valid |-> lane0.valid);

endmodule

`default_nettype wire

//--- verilog/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  issue_pkg::fetch_slot_t slot0,
  input  issue_pkg::fetch_slot_t slot1,
  output logic                   in_ready,
  output issue_pkg::issue_slot_t lane0,
  output issue_pkg::issue_slot_t lane1,
  input  logic                   issue_ready
);
  import issue_pkg::*;

  // Decoded records, one per fetch slot.
  issue_slot_t pre0;
  issue_slot_t pre1;

  instr_predecode i_predecode0 (
    .slot (slot0),
    .op   (pre0)
  );

  instr_predecode i_predecode1 (
    .slot (slot1),
    .op   (pre1)
  );

  issue_buffer i_issue_buffer (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .in0         (pre0),
    .in1         (pre1),
    .in_ready    (in_ready),
    .lane0       (lane0),
    .lane1       (lane1),
    .issue_ready (issue_ready)
  );

endmodule

`default_nettype wire

//--- dv/issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_tb;
  import issue_pkg::*;

  logic        clock;
  logic        reset;
  logic        flush;
  fetch_slot_t slot0;
  fetch_slot_t slot1;
  logic        in_ready;
  issue_slot_t lane0;
  issue_slot_t lane1;
  logic        issue_ready;

  // One entry per case line.
  logic        case_v0[$];
  logic [31:0] case_w0[$];
  logic        case_v1[$];
  logic [31:0] case_w1[$];
  logic [1:0]  case_rdy[$];
  logic        case_flush[$];

  // Accepted words not yet issued, oldest first.
  logic [31:0] model_q[$];

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic        saw_stall = 1'b0;

  issue_top i_dut (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .slot0       (slot0),
    .slot1       (slot1),
    .in_ready    (in_ready),
    .lane0       (lane0),
    .lane1       (lane1),
    .issue_ready (issue_ready)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("errors=%0d checks=%0d", errors, checks);
      $display("sim failed");
      $finish;
    end
  end

  // Expected record for one word, from the RV32IM encoding tables.
  function automatic issue_op_t ref_decode(input logic [31:0] w);
    issue_op_t  r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [2:0] uses;
    f3 = w[14:12];
    f7 = w[31:25];
    r.cls = cls_system;
    case (w[6:0])
      7'h33: begin
        if (f7 == 7'h01) begin
          r.cls = cls_muldiv;
        end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          r.cls = cls_alu;
        end
      end
      7'h13: begin
        if (!(f3 == 3'd1 && f7 != 7'h00) && !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
          r.cls = cls_alu;
        end
      end
      7'h37, 7'h17: r.cls = cls_upper;
      7'h6f: r.cls = cls_jump;
      7'h67: r.cls = (f3 == 3'd0) ? cls_jump : cls_system;
      7'h63: r.cls = (f3[2:1] != 2'b01) ? cls_branch : cls_system;
      7'h03: r.cls = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? cls_load : cls_system;
      7'h23: r.cls = (f3 <= 3'd2) ? cls_store : cls_system;
      default: r.cls = cls_system;
    endcase
    // Register uses as rd, rs1, rs2.
    case (r.cls)
      cls_alu: uses = (w[6:0] == 7'h33) ? 3'b111 : 3'b110;
      cls_muldiv: uses = 3'b111;
      cls_branch, cls_store: uses = 3'b011;
      cls_upper: uses = 3'b100;
      cls_jump: uses = (w[6:0] == 7'h67) ? 3'b110 : 3'b100;
      cls_load: uses = 3'b110;
      default: uses = (w[6:0] == 7'h73 && f3[1:0] != 2'b00) ? {1'b1, !f3[2], 1'b0} : 3'b000;
    endcase
    r.word = w;
    r.rd = w[11:7];
    r.rs1 = w[19:15];
    r.rs2 = w[24:20];
    r.wren = uses[2] && r.rd != 5'd0;
    r.rden1 = uses[1] && r.rs1 != 5'd0;
    r.rden2 = uses[0] && r.rs2 != 5'd0;
    return r;
  endfunction

  function automatic logic pair_allowed(input logic [31:0] older, input logic [31:0] younger);
    issue_op_t o;
    issue_op_t y;
    logic      basic;
    logic      hazard;
    o = ref_decode(older);
    y = ref_decode(younger);
    basic = (y.cls == cls_alu) || (y.cls == cls_branch) ||
            (y.cls == cls_jump) || (y.cls == cls_upper);
    hazard = o.wren && ((y.rden1 && y.rs1 == o.rd) || (y.rden2 && y.rs2 == o.rd));
    return basic && !hazard;
  endfunction

  function automatic logic pick_ready(input logic [1:0] sel);
    logic [31:0] r;
    r = 32'd0;
    if (sel == 2'd2) begin
      r = $urandom;
    end
    return (sel == 2'd2) ? r[0] : sel[0];
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v0;
    logic [31:0] w0;
    logic [31:0] v1;
    logic [31:0] w1;
    logic [7:0]  rdy_ch;
    logic [31:0] fl;
    fd = $fopen("dv/issue_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/issue_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %s %h", v0, w0, v1, w1, rdy_ch, fl);
        if (n == 6) begin
          case_v0.push_back(v0 != 0);
          case_w0.push_back(w0);
          case_v1.push_back(v1 != 0);
          case_w1.push_back(w1);
          case_rdy.push_back((rdy_ch == "r") ? 2'd2 : {1'b0, rdy_ch == "1"});
          case_flush.push_back(fl != 0);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_valid(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_lane(input string name, input issue_op_t got, input logic [31:0] word);
    issue_op_t exp;
    exp = ref_decode(word);
    checks++;
    if (got.word !== word) begin
      $display("ERR t=%0t %s.word exp=%h got=%h", $time, name, word, got.word);
      errors++;
    end else if (got !== exp) begin
      $display("ERR t=%0t %s.op exp=%h got=%h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    check_valid("lane0.valid", 1'b0, lane0.valid);
    check_valid("lane1.valid", 1'b0, lane1.valid);
    check_valid("in_ready", 1'b1, in_ready);
  endtask

  // Runs between edges, so inputs and lanes are settled.
  task automatic check_cycle(output logic accepted);
    logic exp_v1;
    accepted = 1'b0;
    // Occupancy left by the last edge sets the registered ready.
    check_valid("in_ready", model_q.size() <= buffer_depth - 2, in_ready);
    if (!in_ready) begin
      saw_stall = 1'b1;
    end
    if (flush) begin
      check_valid("lane0.valid", 1'b0, lane0.valid);
      check_valid("lane1.valid", 1'b0, lane1.valid);
      model_q.delete();
    end else begin
      // Words accepted now are already visible to the lanes.
      if (slot0.valid && in_ready) begin
        accepted = 1'b1;
        model_q.push_back(slot0.word);
        if (slot1.valid) begin
          model_q.push_back(slot1.word);
        end
      end
      exp_v1 = (model_q.size() >= 2) && pair_allowed(model_q[0], model_q[1]);
      check_valid("lane0.valid", model_q.size() > 0, lane0.valid);
      check_valid("lane1.valid", exp_v1, lane1.valid);
      if (lane0.valid && model_q.size() > 0) begin
        check_lane("lane0", lane0.op, model_q[0]);
      end
      if (lane1.valid && model_q.size() > 1) begin
        check_lane("lane1", lane1.op, model_q[1]);
      end
      if (issue_ready && lane0.valid && model_q.size() > 0) begin
        model_q.delete(0);
      end
      if (issue_ready && lane1.valid && model_q.size() > 0) begin
        model_q.delete(0);
      end
    end
  endtask

  task automatic run_line(input int idx);
    logic acc;
    logic done;
    done = 1'b0;
    @(posedge clock);
    slot0 <= {case_v0[idx], case_w0[idx]};
    slot1 <= {case_v1[idx], case_w1[idx]};
    flush <= case_flush[idx];
    issue_ready <= pick_ready(case_rdy[idx]);
    while (!done) begin
      @(negedge clock);
      check_cycle(acc);
      // Flush and idle lines last one cycle.
      done = acc || case_flush[idx] || !case_v0[idx];
      if (!done) begin
        @(posedge clock);
        issue_ready <= pick_ready(case_rdy[idx]);
      end
    end
  endtask

  task automatic drain();
    logic acc;
    @(posedge clock);
    slot0 <= '0;
    slot1 <= '0;
    flush <= 1'b0;
    issue_ready <= 1'b1;
    @(negedge clock);
    check_cycle(acc);
    while (model_q.size() > 0) begin
      @(posedge clock);
      @(negedge clock);
      check_cycle(acc);
    end
    // An empty model must see idle lanes.
    @(posedge clock);
    @(negedge clock);
    check_cycle(acc);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    flush = 1'b0;
    slot0 = '0;
    slot1 = '0;
    issue_ready = 1'b0;
    void'($urandom(32'hb205));
    load_cases();
    cycle_limit = 4 * case_v0.size() + 200;
    @(posedge clock);
    @(negedge clock);
    check_reset_state();
    @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_reset_state();
    if (case_v0.size() == 0) begin
      $display("No case lines were read from dv/issue_cases.txt");
      errors++;
    end else begin
      for (int i = 0; i < case_v0.size(); i++) begin
        run_line(i);
      end
      drain();
      if (!saw_stall) begin
        $display("in_ready never fell, the buffer was never filled");
        errors++;
      end
    end
    $display("errors=%0d checks=%0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/issue_cases.txt
# slot0_valid slot0_word slot1_valid slot1_word issue_ready flush
# Words are hex RV32IM encodings; issue_ready is 0, 1 or r for random.
# Pairing and decode cases.
1 003100b3 1 00500293 1 0
1 0002a303 1 002083b3 1 0
1 00100413 1 00412483 1 0
1 02208533 1 404185b3 1 0
1 00208633 1 00160693 1 0
1 00208033 1 00300713 1 0
1 12345837 1 008000ef 1 0
1 00208863 1 00312423 1 0
1 300298f3 1 0ff0000f 1 0
1 00000073 1 00000000 1 0
1 00008067 0 00000000 1 0
# Drain.
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
# Back-pressure run fills all eight entries.
1 00500293 1 003100b3 0 0
1 002083b3 1 00208633 0 0
1 00160693 1 404185b3 0 0
1 0002a303 1 12345837 0 0
1 02208533 1 00208033 1 0
# Drain.
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
0 00000000 0 00000000 1 0
# Flush drops queued and incoming words.
1 00500293 1 003100b3 0 0
1 002083b3 1 00208633 0 0
1 00160693 1 404185b3 0 1
1 00208033 1 00300713 1 0
# Random issue_ready.
1 12345837 1 00208863 r 0
1 0002a303 1 00300713 r 0
1 02208533 1 008000ef r 0
1 300298f3 1 00208633 r 0
1 00100413 1 00160693 r 0
1 00312423 1 0ff0000f r 0
1 00008067 0 00000000 r 0

//--- dual_issue.f
verilog/issue_pkg.sv
verilog/instr_predecode.sv
verilog/issue_buffer.sv
verilog/issue_top.sv
dv/issue_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = issue_tb
DUT_TOP    = issue_top
FILELIST   = dual_issue.f
OBJ_DIR    = obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(SIM) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "pass message not found in $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
